//--- logic/mmu_pkg.sv
/*
 * Translation package for the two-channel MMU.
 * Holds the satp mode codes, page-table entry field positions,
 * TLB sizing and the request, response and walk word layouts.
 */
package mmu_pkg;

    localparam int num_chan    = 2;                   // instruction and data
    localparam int chan_w      = (num_chan > 1) ? $clog2(num_chan) : 1;
    localparam int tlb_entries = 4;                   // per bank
    localparam int ent_w       = $clog2(tlb_entries);
    localparam int id_w        = 8;
    localparam int xlen        = 64;
    localparam int vpn_w       = 9;                   // one table index
    localparam int max_level   = 4;                   // top level of Sv57
    localparam int vpn_total_w = (max_level + 1) * vpn_w;
    localparam int lvl_w       = 3;
    localparam int page_bits   = 12;
    localparam int ppn_w       = 44;
    localparam int perm_w      = 8;                   // low flag bits of an entry
    localparam int pte_shift   = 3;                   // eight bytes per entry

    // entry flag positions
    localparam int pte_v       = 0;
    localparam int pte_r       = 1;
    localparam int pte_x       = 3;
    localparam int pte_ppn_lsb = 10;

    localparam int satp_mode_lsb = 60;
    localparam int mode_w        = 4;

    typedef enum logic [mode_w-1:0] {
        sv39 = 4'd8,
        sv48 = 4'd9,
        sv57 = 4'd10
    } satp_mode_e;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [xlen-1:0] vadd;
        logic [xlen-1:0] satp;
    } tlb_req_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [perm_w-1:0] perm;
        logic [xlen-1:0]   padd;
    } tlb_resp_t;

    typedef struct packed {
        logic [id_w-1:0]        id;
        logic [vpn_total_w-1:0] vpn;
        logic [xlen-1:0]        satp;
    } walk_req_t;

    typedef struct packed {
        logic              done;
        logic [ppn_w-1:0]  ppn;
        logic [perm_w-1:0] perm;
    } walk_res_t;

endpackage

//--- logic/mem_pkg.sv
/*
 * Memory-port package: ID-tagged read request and response words,
 * and the state encoding of the page-table walker.
 */
package mem_pkg;

    typedef struct packed {
        logic [mmu_pkg::id_w-1:0] id;
        logic [mmu_pkg::xlen-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [mmu_pkg::id_w-1:0] id;
        logic [mmu_pkg::xlen-1:0] rdat;
    } mem_resp_t;

    typedef enum logic [2:0] {
        idle,
        addr,
        wait_mem,
        check,
        done
    } walk_state_e;

endpackage

//--- logic/tlb_bank.sv
/*
 * Per-channel fully associative TLB.
 * Registers a hit response one cycle after a new request id, otherwise
 * holds a walk request until done, then fills and answers.
 */
`timescale 1ns/1ps

module tlb_bank (
    input  logic               clk,
    input  logic               rst,
    input  logic               fence,
    input  mmu_pkg::tlb_req_t  req,
    output mmu_pkg::tlb_resp_t resp,
    output mmu_pkg::walk_req_t walk_req,
    input  mmu_pkg::walk_res_t walk_res
);
    import mmu_pkg::*;

    logic [tlb_entries-1:0] ent_valid;
    logic [vpn_total_w-1:0] ent_vpn  [tlb_entries];
    logic [xlen-1:0]        ent_satp [tlb_entries];
    logic [ppn_w-1:0]       ent_ppn  [tlb_entries];
    logic [perm_w-1:0]      ent_perm [tlb_entries];
    logic [ent_w-1:0]       fill_ptr;  // round-robin victim
    logic [id_w-1:0]        seen_id;   // last accepted request id
    logic                   stale;     // fence landed during the walk
    logic                   new_req;
    logic                   hit;
    logic [ent_w-1:0]       hit_idx;
    logic                   fill_en;
    logic [vpn_total_w-1:0] req_vpn;

    assign req_vpn = req.vadd[page_bits +: vpn_total_w];
    assign new_req = (req.id != '0) && (req.id != seen_id) && (walk_req.id == '0);
    assign fill_en = walk_res.done && (walk_res.perm != '0) && !stale && !fence;

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int e = 0; e < tlb_entries; e++) begin
            if (!hit && ent_valid[e] && ent_vpn[e] == req_vpn && ent_satp[e] == req.satp) begin
                hit     = 1'b1;
                hit_idx = ent_w'(e);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            fill_ptr  <= '0;
            seen_id   <= '0;
            stale     <= 1'b0;
            resp      <= '0;
            walk_req  <= '0;
        end else begin
            resp <= '0;                                 // one-cycle pulse
            if (req.id == '0) seen_id <= '0;            // lets an idle gap reuse an id
            if (new_req) begin
                seen_id <= req.id;
                if (hit && !fence) begin
                    resp.id   <= req.id;
                    resp.perm <= ent_perm[hit_idx];
                    resp.padd <= xlen'({ent_ppn[hit_idx], req.vadd[page_bits-1:0]});
                end else begin
                    walk_req.id   <= req.id;
                    walk_req.vpn  <= req_vpn;
                    walk_req.satp <= req.satp;
                end
            end
            if (walk_res.done) begin
                resp.id   <= walk_req.id;
                resp.perm <= walk_res.perm;
                resp.padd <= (walk_res.perm == '0) ? '0 :
                             xlen'({walk_res.ppn, req.vadd[page_bits-1:0]});
                walk_req  <= '0;
                stale     <= 1'b0;
            end else if (fence && walk_req.id != '0) begin
                stale <= 1'b1;
            end
            if (fence) begin
                ent_valid <= '0;
            end else if (fill_en) begin
                ent_valid[fill_ptr] <= 1'b1;
                fill_ptr            <= fill_ptr + 1'b1;
            end
        end
    end

    // entry payload, qualified by ent_valid
    always_ff @(posedge clk) begin
        if (fill_en) begin
            ent_vpn[fill_ptr]  <= walk_req.vpn;
            ent_satp[fill_ptr] <= walk_req.satp;
            ent_ppn[fill_ptr]  <= walk_res.ppn;
            ent_perm[fill_ptr] <= walk_res.perm;
        end
    end

endmodule

//--- logic/walk_arbiter.sv
/*
 * Walk arbiter. Grants the lowest-index missing bank, forwards its
 * walk to the walker and routes the result back to that bank only.
 */
`timescale 1ns/1ps

module walk_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  mmu_pkg::walk_req_t bank_req [mmu_pkg::num_chan],
    output mmu_pkg::walk_res_t bank_res [mmu_pkg::num_chan],
    output mmu_pkg::walk_req_t walk_req,
    input  mmu_pkg::walk_res_t walk_res
);
    import mmu_pkg::*;

    logic              busy;
    logic [chan_w-1:0] gnt;
    logic              pick_valid;
    logic [chan_w-1:0] pick;

    // scan downward so the lowest waiting bank wins
    always_comb begin
        pick_valid = 1'b0;
        pick       = '0;
        for (int c = num_chan - 1; c >= 0; c--) begin
            if (bank_req[c].id != '0) begin
                pick_valid = 1'b1;
                pick       = chan_w'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            gnt  <= '0;
        end else if (busy) begin
            if (walk_res.done) busy <= 1'b0;            // free one cycle after done
        end else if (pick_valid) begin
            busy <= 1'b1;
            gnt  <= pick;
        end
    end

    assign walk_req = busy ? bank_req[gnt] : '0;

    always_comb begin
        for (int c = 0; c < num_chan; c++) begin
            bank_res[c] = (busy && gnt == chan_w'(c)) ? walk_res : '0;
        end
    end

endmodule

//--- logic/page_walker.sv
/*
 * Shared page-table walker for Sv39, Sv48 and Sv57.
 * Reads one entry per level over the memory port, merges superpage
 * indices and returns perm zero on any fault.
 */
`timescale 1ns/1ps

module page_walker (
    input  logic               clk,
    input  logic               rst,
    input  mmu_pkg::walk_req_t walk_req,
    output mmu_pkg::walk_res_t walk_res,
    output mem_pkg::mem_req_t  mem_req,
    input  mem_pkg::mem_resp_t mem_resp
);
    import mmu_pkg::*;
    import mem_pkg::*;

    walk_state_e                   state;
    logic [id_w-1:0]               cur_id;
    logic [max_level:0][vpn_w-1:0] vpn_idx;     // virtual index per level
    logic [ppn_w-1:0]              ppn;         // current table, then result
    logic [perm_w-1:0]             perm;
    logic [lvl_w-1:0]              level;
    logic [xlen-1:0]               pte;
    logic [xlen-1:0]               pte_addr;
    logic [ppn_w-1:0]              leaf_ppn;
    logic                          misaligned;
    satp_mode_e                    mode;

    assign mode = satp_mode_e'(walk_req.satp[satp_mode_lsb +: mode_w]);

    // superpage leaf: lower ppn fields must be zero and take the virtual indices
    always_comb begin
        leaf_ppn   = pte[pte_ppn_lsb +: ppn_w];
        misaligned = 1'b0;
        for (int i = 0; i < max_level; i++) begin
            if (lvl_w'(i) < level) begin
                if (leaf_ppn[i*vpn_w +: vpn_w] != '0) misaligned = 1'b1;
                leaf_ppn[i*vpn_w +: vpn_w] = vpn_idx[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            cur_id <= '0;
        end else begin
            case (state)
                idle: begin
                    if (walk_req.id != '0) begin
                        cur_id  <= walk_req.id;
                        vpn_idx <= walk_req.vpn;
                        ppn     <= walk_req.satp[ppn_w-1:0];   // root table
                        perm    <= '0;
                        state   <= addr;
                        case (mode)
                            sv39:    level <= 3'd2;
                            sv48:    level <= 3'd3;
                            sv57:    level <= 3'd4;
                            default: state <= done;            // unknown mode faults
                        endcase
                    end
                end
                addr: begin
                    pte_addr <= xlen'({ppn, page_bits'(0)}) + (xlen'(vpn_idx[level]) << pte_shift);
                    state    <= wait_mem;
                end
                wait_mem: begin
                    if (mem_resp.id == cur_id) begin
                        pte   <= mem_resp.rdat;
                        state <= check;
                    end
                end
                check: begin
                    state <= done;
                    if (!pte[pte_v]) begin
                        perm <= '0;                            // invalid entry
                    end else if (pte[pte_r] || pte[pte_x]) begin
                        if (misaligned) begin
                            perm <= '0;
                        end else begin
                            ppn  <= leaf_ppn;
                            perm <= pte[perm_w-1:0];
                        end
                    end else if (level == '0) begin
                        perm <= '0;                            // pointer at the last level
                    end else begin
                        ppn   <= pte[pte_ppn_lsb +: ppn_w];
                        level <= level - 1'b1;
                        state <= addr;
                    end
                end
                done:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        mem_req.id   = (state == wait_mem) ? cur_id : '0;  // held until the id matches
        mem_req.addr = pte_addr;
    end

    always_comb begin
        walk_res.done = (state == done);
        walk_res.ppn  = ppn;
        walk_res.perm = perm;
    end

endmodule

//--- logic/mmu_top.sv
/*
 * MMU top level. Packs the instruction and data channels into arrays
 * feeding one TLB bank each, sharing a single page-table walker.
 */
`timescale 1ns/1ps

module mmu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               fence,
    input  mmu_pkg::tlb_req_t  it_req,
    input  mmu_pkg::tlb_req_t  dt_req,
    output mmu_pkg::tlb_resp_t it_resp,
    output mmu_pkg::tlb_resp_t dt_resp,
    output mem_pkg::mem_req_t  mem_req,
    input  mem_pkg::mem_resp_t mem_resp
);
    import mmu_pkg::*;

    tlb_req_t  chan_req  [num_chan];
    tlb_resp_t chan_resp [num_chan];
    walk_req_t bank_walk_req [num_chan];
    walk_res_t bank_walk_res [num_chan];
    walk_req_t walk_req;
    walk_res_t walk_res;

    assign chan_req[0] = it_req;    // channel 0 is instruction
    assign chan_req[1] = dt_req;
    assign it_resp     = chan_resp[0];
    assign dt_resp     = chan_resp[1];

    generate
        for (genvar c = 0; c < num_chan; c++) begin : g_bank
            tlb_bank i_bank (
                .clk      (clk),
                .rst      (rst),
                .fence    (fence),
                .req      (chan_req[c]),
                .resp     (chan_resp[c]),
                .walk_req (bank_walk_req[c]),
                .walk_res (bank_walk_res[c])
            );
        end
    endgenerate

    walk_arbiter i_arbiter (
        .clk      (clk),
        .rst      (rst),
        .bank_req (bank_walk_req),
        .bank_res (bank_walk_res),
        .walk_req (walk_req),
        .walk_res (walk_res)
    );

    page_walker i_walker (
        .clk      (clk),
        .rst      (rst),
        .walk_req (walk_req),
        .walk_res (walk_res),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule

//--- tb/mmu_properties.sv
/*
 * Port protocol assertions, bound into the page walker and the TLB banks.
 * Ports that a host does not have are tied to idle values.
 */
`timescale 1ns/1ps

module mmu_properties (
    input logic                     clk,
    input logic                     rst,
    input mem_pkg::walk_state_e     state,
    input mem_pkg::mem_req_t        mem_req,
    input mem_pkg::mem_resp_t       mem_resp,
    input mmu_pkg::walk_res_t       walk_res,
    input logic [mmu_pkg::id_w-1:0] req_id,
    input logic [mmu_pkg::id_w-1:0] resp_id
);
    import mem_pkg::*;

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req.id != '0 && mem_resp.id != mem_req.id) |=> $stable(mem_req))
        else $error("mem_req changed before its response arrived");

    // response pulse carries the id that was held on the request
    resp_matches_req: assert property (@(posedge clk) disable iff (rst)
        (resp_id != '0) |-> (resp_id == $past(req_id)))
        else $error("response id differs from the held request id");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (state == idle && mem_req.id == '0 && resp_id == '0 && !walk_res.done))
        else $error("outputs not idle when reset is released");

endmodule

bind page_walker mmu_properties i_walker_props (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .mem_req  (mem_req),
    .mem_resp (mem_resp),
    .walk_res (walk_res),
    .req_id   ('0),
    .resp_id  ('0)
);

bind tlb_bank mmu_properties i_bank_props (
    .clk      (clk),
    .rst      (rst),
    .state    (mem_pkg::idle),
    .mem_req  ('0),
    .mem_resp ('0),
    .walk_res (walk_res),
    .req_id   (req.id),
    .resp_id  (resp.id)
);

//--- tb/tb_mmu_top.sv
/*
 * Testbench for the MMU top level. A page-table memory model answers
 * with random latency while a table of translations is applied and checked.
 */
`timescale 1ns/1ps

module tb_mmu_top;
    import mmu_pkg::*;
    import mem_pkg::*;

    localparam int          resp_timeout = 200;                 // cycles per response
    localparam logic [63:0] satp_sv39    = 64'h8000_0000_0000_0100;
    localparam logic [63:0] satp_sv48    = 64'h9000_0000_0000_0200;
    localparam logic [63:0] satp_bad     = 64'h5000_0000_0000_0100;  // mode 5

    typedef struct packed {
        logic        chan;          // 0 instruction, 1 data
        logic        pair;          // issued together with the next row
        logic        fence_first;
        logic [7:0]  id;
        logic [63:0] vadd;
        logic [63:0] satp;
        logic [63:0] exp_padd;
        logic [7:0]  exp_perm;
        logic [3:0]  exp_reads;
    } row_t;

    logic        clk;
    logic        rst;
    logic        fence;
    tlb_req_t    it_req;
    tlb_req_t    dt_req;
    tlb_resp_t   it_resp;
    tlb_resp_t   dt_resp;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;
    logic [63:0] pt_mem [logic [63:0]];   // entries by byte address
    row_t        rows [$];
    int          reads;
    int          errors;
    int          tests;

    mmu_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .fence    (fence),
        .it_req   (it_req),
        .dt_req   (dt_req),
        .it_resp  (it_resp),
        .dt_resp  (dt_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] ptr_pte(input logic [43:0] ppn);
        return {10'h0, ppn, 10'h001};     // valid, no r/w/x
    endfunction

    function automatic logic [63:0] leaf_pte(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'h0, ppn, 2'b00, flags};
    endfunction

    task automatic put_pte(input logic [43:0] table_ppn, input int idx, input logic [63:0] pte);
        pt_mem[{8'h0, table_ppn, 12'h000} + 64'(idx * 8)] = pte;
    endtask

    task automatic build_tables();
        put_pte(44'h100, 1, ptr_pte(44'h101));              // Sv39 root
        put_pte(44'h101, 2, ptr_pte(44'h102));              // index 9 left empty
        put_pte(44'h102, 3, leaf_pte(44'h5a5, 8'hcf));
        put_pte(44'h102, 4, leaf_pte(44'h7c7, 8'hcb));
        put_pte(44'h200, 0, ptr_pte(44'h201));              // Sv48 root
        put_pte(44'h201, 4, ptr_pte(44'h202));
        put_pte(44'h202, 5, leaf_pte(44'h1400, 8'hc7));     // aligned 2 MiB
        put_pte(44'h202, 7, leaf_pte(44'h1401, 8'hc7));     // misaligned 2 MiB
        put_pte(44'h202, 8, ptr_pte(44'h203));
        put_pte(44'h203, 1, leaf_pte(44'h8d8, 8'hc7));
    endtask

    // the OS moves the first code page before fencing
    task automatic remap_code_page();
        put_pte(44'h102, 3, leaf_pte(44'h6b6, 8'hcf));
    endtask

    task automatic add_row(input int chan, input int pair, input int fence_first,
                           input logic [7:0] id, input logic [63:0] vadd,
                           input logic [63:0] satp, input logic [63:0] padd,
                           input logic [7:0] perm, input int n_reads);
        rows.push_back('{1'(chan), 1'(pair), 1'(fence_first), id, vadd, satp,
                         padd, perm, 4'(n_reads)});
    endtask

    task automatic load_table();
        add_row(0, 0, 0, 8'h01, 64'h4040_3456, satp_sv39, 64'h5a_5456, 8'hcf, 3);
        add_row(0, 0, 0, 8'h02, 64'h4040_3456, satp_sv39, 64'h5a_5456, 8'hcf, 0);
        add_row(1, 0, 0, 8'h03, 64'h1_00a0_6789, satp_sv48, 64'h140_6789, 8'hc7, 3);
        add_row(1, 0, 0, 8'h04, 64'h1_00e0_6789, satp_sv48, 64'h0, 8'h00, 3);
        add_row(1, 0, 0, 8'h05, 64'h4120_0010, satp_sv39, 64'h0, 8'h00, 2);  // empty entry
        add_row(1, 0, 0, 8'h06, 64'h4120_0010, satp_sv39, 64'h0, 8'h00, 2);  // walks again
        add_row(0, 0, 0, 8'h07, 64'h4040_3456, satp_bad, 64'h0, 8'h00, 0);
        add_row(0, 0, 1, 8'h08, 64'h4040_3456, satp_sv39, 64'h6b_6456, 8'hcf, 3);
        add_row(0, 0, 0, 8'h09, 64'h4040_3456, satp_sv39, 64'h6b_6456, 8'hcf, 0);
        add_row(0, 1, 0, 8'h0a, 64'h4040_4abc, satp_sv39, 64'h7c_7abc, 8'hcb, 3);
        add_row(1, 0, 0, 8'h0b, 64'h1_0100_1234, satp_sv48, 64'h8d_8234, 8'hc7, 4);
    endtask

    // memory model: one entry per request after 0 to 5 cycles
    initial begin
        int unsigned delay;
        logic [63:0] rdat;
        void'($urandom(32'hf38c));
        mem_resp = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req.id != '0) begin
                reads++;
                delay = $urandom % 6;
                rdat  = pt_mem.exists(mem_req.addr) ? pt_mem[mem_req.addr] : 64'h0;
                repeat (delay) @(negedge clk);
                mem_resp <= '{id: mem_req.id, rdat: rdat};
                @(negedge clk);
                mem_resp <= '0;
            end
        end
    end

    task automatic drive_req(input logic chan, input tlb_req_t req_word);
        if (chan) begin
            dt_req <= req_word;
        end else begin
            it_req <= req_word;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests %0d, errors %0d", tests, errors + 1);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic run_request(input row_t r);
        tlb_resp_t got;
        int        cycles;
        bit        seen;
        string     name;
        name   = r.chan ? "dt_resp" : "it_resp";
        cycles = 0;
        seen   = 1'b0;
        @(negedge clk);
        drive_req(r.chan, '{id: r.id, vadd: r.vadd, satp: r.satp});
        while (!seen && cycles < resp_timeout) begin
            @(negedge clk);
            cycles++;
            got  = r.chan ? dt_resp : it_resp;
            seen = (got.id == r.id);
        end
        if (!seen) begin
            abort_run($sformatf("timeout: no response on %s for id %h", name, r.id));
        end else begin
            drive_req(r.chan, '0);
            assert (got.padd == r.exp_padd) else begin
                $display("error: %s.padd got %h expected %h", name, got.padd, r.exp_padd);
                errors++;
            end
            assert (got.perm == r.exp_perm) else begin
                $display("error: %s.perm got %h expected %h", name, got.perm, r.exp_perm);
                errors++;
            end
            // a cached translation answers on the next cycle
            if (r.exp_reads == 0 && r.exp_perm != 0) begin
                assert (cycles == 1) else begin
                    $display("hit for id %h took %0d cycles instead of one", r.id, cycles);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int idx;
        int span;
        int reads_before;
        int errors_before;
        int exp_reads;
        rst    = 1'b1;
        fence  = 1'b0;
        it_req = '0;
        dt_req = '0;
        reads  = 0;
        errors = 0;
        tests  = 0;
        build_tables();
        load_table();
        repeat (8) @(negedge clk);
        rst <= 1'b0;
        idx = 0;
        while (idx < rows.size()) begin
            if (rows[idx].fence_first) begin
                remap_code_page();
                @(negedge clk);
                fence <= 1'b1;
                @(negedge clk);
                fence <= 1'b0;
            end
            reads_before  = reads;
            errors_before = errors;
            if (rows[idx].pair && idx + 1 < rows.size()) begin
                fork
                    run_request(rows[idx]);
                    run_request(rows[idx + 1]);
                join
                exp_reads = int'(rows[idx].exp_reads) + int'(rows[idx + 1].exp_reads);
                span      = 2;
            end else begin
                run_request(rows[idx]);
                exp_reads = int'(rows[idx].exp_reads);
                span      = 1;
            end
            assert (reads - reads_before == exp_reads) else begin
                $display("error: mem_req count got %h expected %h", reads - reads_before,
                         exp_reads);
                errors++;
            end
            tests++;
            $display("test %0d (row %0d, %0d request(s)): %s", tests, idx, span,
                     (errors == errors_before) ? "ok" : "mismatch");
            idx += span;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- mmu_top.f
logic/mmu_pkg.sv
logic/mem_pkg.sv
logic/tlb_bank.sv
logic/walk_arbiter.sv
logic/page_walker.sv
logic/mmu_top.sv
tb/mmu_properties.sv
tb/tb_mmu_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mmu_top
FLIST     := mmu_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED
SOURCES   := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
